// File: all.f
+incdir+include
hw/ecc_pkg.sv
hw/ecc_69_codec.sv
hw/ecc_mem_array.sv
hw/ecc_scrub_ctrl.sv
hw/ecc_mem_top.sv
tests/ecc_mem_tb.sv

// File: hw/ecc_69_codec.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_69_codec (
    input  ecc_pkg::ecc_data_t   data_in,
    output ecc_pkg::ecc_data_t   data_out,
    input  ecc_pkg::ecc_parity_t parity_in,
    output ecc_pkg::ecc_parity_t parity_out,
    input  logic                 bypass,
    output ecc_pkg::ecc_data_t   mask,
    output logic                 sbit_err,
    output logic                 dbit_err
);
    import ecc_pkg::*;

    // ****************************************
    // Check matrix
    // ****************************************
    // One column per data bit, each of odd weight.
    localparam ecc_parity_t H_COL [`ECC_DATA_WIDTH] = '{
        8'b10000011, 8'b10000101, 8'b10000110, 8'b00000111, 8'b10001001, 8'b10001010, // 0.
        8'b00001011, 8'b10001100, 8'b00001101, 8'b00001110, 8'b10001111, 8'b10010001,
        8'b10010010, 8'b00010011, 8'b10010100, 8'b00010101, 8'b00010110, 8'b10010111, // 12.
        8'b10011000, 8'b00011001, 8'b00011010, 8'b10011011, 8'b00011100, 8'b10011101,
        8'b10011110, 8'b00011111, 8'b10100001, 8'b10100010, 8'b00100011, 8'b10100100, // 24.
        8'b00100101, 8'b00100110, 8'b10100111, 8'b10101000, 8'b00101001, 8'b00101010,
        8'b10101011, 8'b00101100, 8'b10101101, 8'b10101110, 8'b00101111, 8'b10110000, // 36.
        8'b00110001, 8'b00110010, 8'b10110011, 8'b00110100, 8'b10110101, 8'b10110110,
        8'b00110111, 8'b00111000, 8'b10111001, 8'b10111010, 8'b00111011, 8'b10111100, // 48.
        8'b00111101, 8'b00111110, 8'b10111111, 8'b11000001, 8'b11000010, 8'b01000011,
        8'b11000100, 8'b01000101, 8'b01000110, 8'b11000111, 8'b11001000, 8'b01001001, // 60.
        8'b01001010, 8'b11001011, 8'b01001100
    };

    ecc_parity_t syndrome;
    logic        col_hit;
    logic        chk_hit;
    logic        sbit_raw;
    logic        dbit_raw;

    // Each check bit is the XOR of the data bits whose column has it set.
    function automatic ecc_parity_t ecc_encode(input ecc_data_t d);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ H_COL[i];
            end
        end
        return p;
    endfunction

    // ****************************************
    // Encode and syndrome
    // ****************************************
    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // Syndrome lookup.
    always_comb begin
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            mask[i] = (syndrome == H_COL[i]);
        end
    end

    assign col_hit  = |mask;             // Data bit error.
    assign chk_hit  = $onehot(syndrome); // Check bit error.
    assign sbit_raw = col_hit | chk_hit;
    assign dbit_raw = (syndrome != '0) & ~sbit_raw;

    // Raw word and quiet flags in bypass.
    assign data_out = bypass ? data_in : data_in ^ mask;
    assign sbit_err = bypass ? 1'b0 : sbit_raw;
    assign dbit_err = bypass ? 1'b0 : dbit_raw;

endmodule

// File: hw/ecc_mem_array.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_mem_array (
    input  logic                 clk,
    input  logic                 wr_en,
    input  ecc_pkg::ecc_addr_t   wr_addr,
    input  ecc_pkg::ecc_data_t   wr_data,
    input  ecc_pkg::ecc_parity_t wr_parity,
    input  logic                 rd_en,
    input  ecc_pkg::ecc_addr_t   rd_addr,
    output ecc_pkg::ecc_data_t   rd_data,
    output ecc_pkg::ecc_parity_t rd_parity
);
    import ecc_pkg::*;

    ecc_data_t   data_mem   [`ECC_DEPTH];
    ecc_parity_t parity_mem [`ECC_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr]   <= wr_data;
            parity_mem[wr_addr] <= wr_parity;
        end
    end

    // Read port. Gives the old word on a same-edge write.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data   <= data_mem[rd_addr];
            rd_parity <= parity_mem[rd_addr];
        end
    end

    // ****************************************
    // Checks
    // ****************************************
    a_wr_addr_known: assert property (@(posedge clk)
        wr_en |-> !$isunknown(wr_addr))
        else $error("array write with unknown address");

    a_rd_addr_known: assert property (@(posedge clk)
        rd_en |-> !$isunknown(rd_addr))
        else $error("array read with unknown address");

endmodule

// File: hw/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  ecc_pkg::ecc_addr_t   wr_addr,
    input  ecc_pkg::ecc_data_t   wr_data,
    input  ecc_pkg::ecc_data_t   wr_data_flip,
    input  ecc_pkg::ecc_parity_t wr_parity_flip,
    input  logic                 rd_en,
    input  ecc_pkg::ecc_addr_t   rd_addr,
    input  logic                 bypass,
    input  logic                 scrub_en,
    output logic                 rd_valid,
    output ecc_pkg::ecc_data_t   rd_data,
    output logic                 rd_sbit_err,
    output logic                 rd_dbit_err,
    output ecc_pkg::ecc_count_t  corr_count
);
    import ecc_pkg::*;

    logic        mem_wr_en;
    ecc_addr_t   mem_wr_addr;
    ecc_data_t   mem_wr_data;
    logic        inject_sel;
    logic        mem_rd_en;
    ecc_addr_t   mem_rd_addr;
    logic        dec_bypass;
    ecc_parity_t enc_parity;
    ecc_data_t   arr_wr_data;
    ecc_parity_t arr_wr_parity;
    ecc_data_t   arr_rd_data;
    ecc_parity_t arr_rd_parity;

    // ****************************************
    // Write path
    // ****************************************
    ecc_69_codec i_enc (
        .data_in    (mem_wr_data),
        .data_out   (),
        .parity_in  ('0),
        .parity_out (enc_parity),
        .bypass     (1'b1),
        .mask       (),
        .sbit_err   (),
        .dbit_err   ()
    );

    // Error injection.
    assign arr_wr_data   = inject_sel ? mem_wr_data ^ wr_data_flip : mem_wr_data;
    assign arr_wr_parity = inject_sel ? enc_parity ^ wr_parity_flip : enc_parity;

    ecc_mem_array i_array (
        .clk       (clk),
        .wr_en     (mem_wr_en),
        .wr_addr   (mem_wr_addr),
        .wr_data   (arr_wr_data),
        .wr_parity (arr_wr_parity),
        .rd_en     (mem_rd_en),
        .rd_addr   (mem_rd_addr),
        .rd_data   (arr_rd_data),
        .rd_parity (arr_rd_parity)
    );

    // ****************************************
    // Read path
    // ****************************************
    ecc_69_codec i_dec (
        .data_in    (arr_rd_data),
        .data_out   (rd_data),
        .parity_in  (arr_rd_parity),
        .parity_out (),
        .bypass     (dec_bypass),
        .mask       (),
        .sbit_err   (rd_sbit_err),
        .dbit_err   (rd_dbit_err)
    );

    ecc_scrub_ctrl i_scrub (
        .clk          (clk),
        .rst          (rst),
        .host_wr_en   (wr_en),
        .host_wr_addr (wr_addr),
        .host_wr_data (wr_data),
        .host_rd_en   (rd_en),
        .host_rd_addr (rd_addr),
        .host_bypass  (bypass),
        .scrub_en     (scrub_en),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .inject_sel   (inject_sel),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .dec_bypass   (dec_bypass),
        .dec_data     (rd_data),
        .dec_sbit_err (rd_sbit_err),
        .rd_valid     (rd_valid),
        .corr_count   (corr_count)
    );

endmodule

// File: hw/ecc_pkg.sv
`include "ecc_params.svh"

package ecc_pkg;

    // Data word. Also used for flip and correction masks.
    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t; // Check bits or syndrome.
    typedef logic [`ECC_ADDR_WIDTH-1:0]   ecc_addr_t;
    typedef logic [`ECC_COUNT_WIDTH-1:0]  ecc_count_t;

    // Scrubber FSM.
    typedef enum logic [1:0] {
        SCRUB_IDLE,  // No scrub read outstanding.
        SCRUB_CHECK, // Scrub word on the decoder.
        SCRUB_FIX    // Waiting for a write slot.
    } scrub_state_t;

endpackage

// File: hw/ecc_scrub_ctrl.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_scrub_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                host_wr_en,
    input  ecc_pkg::ecc_addr_t  host_wr_addr,
    input  ecc_pkg::ecc_data_t  host_wr_data,
    input  logic                host_rd_en,
    input  ecc_pkg::ecc_addr_t  host_rd_addr,
    input  logic                host_bypass,
    input  logic                scrub_en,
    output logic                mem_wr_en,
    output ecc_pkg::ecc_addr_t  mem_wr_addr,
    output ecc_pkg::ecc_data_t  mem_wr_data,
    output logic                inject_sel,
    output logic                mem_rd_en,
    output ecc_pkg::ecc_addr_t  mem_rd_addr,
    output logic                dec_bypass,
    input  ecc_pkg::ecc_data_t  dec_data,
    input  logic                dec_sbit_err,
    output logic                rd_valid,
    output ecc_pkg::ecc_count_t corr_count
);
    import ecc_pkg::*;

    scrub_state_t state;
    ecc_addr_t    scrub_addr;
    ecc_addr_t    next_addr;
    ecc_data_t    fix_data;   // Corrected word awaiting write-back.
    logic         host_hit;   // Host writes the word under scrub.
    logic         scrub_rd;
    logic         scrub_wr;

    assign host_hit  = host_wr_en && (host_wr_addr == scrub_addr);
    assign next_addr = (scrub_addr == ecc_addr_t'(`ECC_DEPTH - 1)) ?
                       '0 : scrub_addr + 1'b1;

    // A host write at the read edge would make the scrub copy stale.
    assign scrub_rd = (state == SCRUB_IDLE) && scrub_en && !host_rd_en && !host_hit;
    assign scrub_wr = (state == SCRUB_FIX) && !host_wr_en;

    // ****************************************
    // Array port muxes with host priority
    // ****************************************
    assign mem_wr_en   = host_wr_en | scrub_wr;
    assign mem_wr_addr = host_wr_en ? host_wr_addr : scrub_addr;
    assign mem_wr_data = host_wr_en ? host_wr_data : fix_data;
    assign inject_sel  = host_wr_en; // Flips only on host writes.

    assign mem_rd_en   = host_rd_en | scrub_rd;
    assign mem_rd_addr = host_rd_en ? host_rd_addr : scrub_addr;

    // Host read status lined up with the array output.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid   <= 1'b0;
            dec_bypass <= 1'b0;
        end else begin
            rd_valid   <= host_rd_en;
            dec_bypass <= host_rd_en && host_bypass;
        end
    end

    // ****************************************
    // Scrub FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SCRUB_IDLE;
            scrub_addr <= '0;
            corr_count <= '0;
        end else begin
            case (state)
                SCRUB_IDLE: begin
                    if (scrub_rd) begin
                        state <= SCRUB_CHECK;
                    end
                end
                SCRUB_CHECK: begin
                    if (dec_sbit_err && !host_hit) begin
                        state <= SCRUB_FIX;
                    end else begin
                        state      <= SCRUB_IDLE;
                        scrub_addr <= next_addr;
                    end
                end
                SCRUB_FIX: begin
                    if (host_hit || scrub_wr) begin // Repair done or dropped.
                        state      <= SCRUB_IDLE;
                        scrub_addr <= next_addr;
                    end
                    if (scrub_wr) begin
                        corr_count <= corr_count + 1'b1;
                    end
                end
                default: state <= SCRUB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCRUB_CHECK && dec_sbit_err) begin
            fix_data <= dec_data;
        end
    end

    // ****************************************
    // Checks
    // ****************************************
    // A counted repair never shares its edge with a host write.
    a_fix_no_host_wr: assert property (@(posedge clk) disable iff (rst)
        $changed(corr_count) |-> !$past(host_wr_en))
        else $error("scrub write-back collided with a host write");

    a_scrub_rd_quiet: assert property (@(posedge clk) disable iff (rst)
        scrub_rd |=> !rd_valid)
        else $error("rd_valid after a scrub-only read");

endmodule

// File: include/ecc_params.svh
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Codeword geometry.
`define ECC_DATA_WIDTH   69
`define ECC_PARITY_WIDTH 8

// Array size.
`define ECC_ADDR_WIDTH   5
`define ECC_DEPTH        32

`define ECC_COUNT_WIDTH  16 // Repair counter.

`endif

// File: tests/ecc_mem_tb.sv
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_mem_tb;
    import ecc_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int TOTAL_BITS   = `ECC_DATA_WIDTH + `ECC_PARITY_WIDTH;
    localparam int N_OPS        = 30;                 // Reads or writes per test.
    localparam int SCRUB_CYCLES = 3 * `ECC_DEPTH * 3; // Three passes at up to three cycles a word.
    localparam int RUN_CYCLES   = 16 + 4 * `ECC_DEPTH + 9 * N_OPS + SCRUB_CYCLES;

    logic        clk;
    logic        rst;
    logic        wr_en;
    ecc_addr_t   wr_addr;
    ecc_data_t   wr_data;
    ecc_data_t   wr_data_flip;
    ecc_parity_t wr_parity_flip;
    logic        rd_en;
    ecc_addr_t   rd_addr;
    logic        bypass;
    logic        scrub_en;
    logic        rd_valid;
    ecc_data_t   rd_data;
    logic        rd_sbit_err;
    logic        rd_dbit_err;
    ecc_count_t  corr_count;

    ecc_parity_t h_col [`ECC_DATA_WIDTH];
    ecc_data_t   shadow_data [`ECC_DEPTH];
    ecc_parity_t shadow_parity [`ECC_DEPTH];
    ecc_data_t   clean_data [`ECC_DEPTH];
    logic        is_single [`ECC_DEPTH];
    logic [31:0] lcg_state;
    int          n_errors;
    int          n_tests;

    ecc_mem_top i_ecc_mem_top (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_data_flip   (wr_data_flip),
        .wr_parity_flip (wr_parity_flip),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .bypass         (bypass),
        .scrub_en       (scrub_en),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .rd_sbit_err    (rd_sbit_err),
        .rd_dbit_err    (rd_dbit_err),
        .corr_count     (corr_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // Reference model
    // ****************************************
    // Low seven bits count up past one-hot values. Bit 7 makes the weight odd.
    function automatic ecc_parity_t column_of(input int idx);
        int          v;
        int          n;
        ecc_parity_t c;
        v = 2;
        n = -1;
        while (n < idx) begin
            v++;
            if ($countones(v[6:0]) > 1) begin
                n++;
            end
        end
        c[6:0] = v[6:0];
        c[7]   = ~^v[6:0];
        return c;
    endfunction

    function automatic ecc_parity_t model_encode(input ecc_data_t d);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ h_col[i];
            end
        end
        return p;
    endfunction

    task automatic decode_model(input ecc_data_t d, input ecc_parity_t p,
                                output ecc_data_t dout, output logic sbit, output logic dbit);
        ecc_parity_t syn;
        syn  = p ^ model_encode(d);
        dout = d;
        sbit = 1'b0;
        dbit = 1'b0;
        if ($onehot(syn)) begin
            sbit = 1'b1; // Check bit hit.
        end else if (syn != '0) begin
            dbit = 1'b1;
            for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                if (syn == h_col[i]) begin
                    dout[i] = ~d[i];
                    sbit    = 1'b1;
                    dbit    = 1'b0;
                end
            end
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return (lcg_next() >> 16) % n;
    endfunction

    function automatic ecc_data_t rand_data();
        logic [95:0] r;
        r = {lcg_next(), lcg_next(), lcg_next()};
        return r[`ECC_DATA_WIDTH-1:0];
    endfunction

    // n distinct flips inside bits lo to lo+span-1 of the codeword.
    task automatic pick_flips(input int lo, input int span, input int n,
                              output ecc_data_t dflip, output ecc_parity_t pflip);
        logic [TOTAL_BITS-1:0] all;
        int                    a;
        int                    b;
        all    = '0;
        a      = lo + rand_below(span);
        all[a] = 1'b1;
        if (n == 2) begin
            b = lo + rand_below(span - 1);
            if (b >= a) begin
                b++;
            end
            all[b] = 1'b1;
        end
        dflip = all[`ECC_DATA_WIDTH-1:0];
        pflip = all[TOTAL_BITS-1:`ECC_DATA_WIDTH];
    endtask

    // ****************************************
    // Host port drivers and checks
    // ****************************************
    task automatic report_err(input string name, input ecc_data_t exp, input ecc_data_t got);
        $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        n_errors++;
    endtask

    task automatic write_word(input ecc_addr_t addr, input ecc_data_t d,
                              input ecc_data_t dflip, input ecc_parity_t pflip);
        wr_en               = 1'b1;
        wr_addr             = addr;
        wr_data             = d;
        wr_data_flip        = dflip;
        wr_parity_flip      = pflip;
        shadow_data[addr]   = d ^ dflip;
        shadow_parity[addr] = model_encode(d) ^ pflip;
        @(negedge clk);
        wr_en          = 1'b0;
        wr_data_flip   = '0;
        wr_parity_flip = '0;
    endtask

    task automatic read_check(input ecc_addr_t addr, input logic byp);
        ecc_data_t exp_data;
        logic      exp_sbit;
        logic      exp_dbit;
        if (byp) begin
            exp_data = shadow_data[addr]; // Raw word.
            exp_sbit = 1'b0;
            exp_dbit = 1'b0;
        end else begin
            decode_model(shadow_data[addr], shadow_parity[addr], exp_data, exp_sbit, exp_dbit);
        end
        rd_en   = 1'b1;
        rd_addr = addr;
        bypass  = byp;
        @(negedge clk);
        if (rd_valid !== 1'b1) begin
            report_err("rd_valid", 1, rd_valid);
        end
        if (rd_data !== exp_data) begin
            report_err("rd_data", exp_data, rd_data);
        end
        if (rd_sbit_err !== exp_sbit) begin
            report_err("rd_sbit_err", exp_sbit, rd_sbit_err);
        end
        if (rd_dbit_err !== exp_dbit) begin
            report_err("rd_dbit_err", exp_dbit, rd_dbit_err);
        end
        rd_en  = 1'b0;
        bypass = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("test %s finished with %0d errors", name, n_errors - err_start);
        n_tests++;
    endtask

    // Write then read back N_OPS words with the given flips.
    task automatic run_injection(input string name, input int lo, input int span,
                                 input int n, input logic byp);
        int          err_start;
        ecc_addr_t   addr;
        ecc_data_t   dflip;
        ecc_parity_t pflip;
        err_start = n_errors;
        for (int k = 0; k < N_OPS; k++) begin
            pick_flips(lo, span, n, dflip, pflip);
            addr = ecc_addr_t'(rand_below(`ECC_DEPTH));
            write_word(addr, rand_data(), dflip, pflip);
            read_check(addr, byp);
        end
        finish_test(name, err_start);
    endtask

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        int          err_start;
        int          n_single;
        int          kind;
        ecc_data_t   dflip;
        ecc_parity_t pflip;
        rst            = 1'b1;
        wr_en          = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        wr_data_flip   = '0;
        wr_parity_flip = '0;
        rd_en          = 1'b0;
        rd_addr        = '0;
        bypass         = 1'b0;
        scrub_en       = 1'b0;
        lcg_state      = 32'd31;
        n_errors       = 0;
        n_tests        = 0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            h_col[i] = column_of(i);
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        err_start = n_errors;
        for (int i = 0; i < `ECC_DEPTH; i++) begin
            write_word(ecc_addr_t'(i), rand_data(), '0, '0);
        end
        for (int k = 0; k < N_OPS; k++) begin
            read_check(ecc_addr_t'(rand_below(`ECC_DEPTH)), 1'b0); // Back to back.
        end
        @(negedge clk);
        if (rd_valid !== 1'b0) begin
            report_err("rd_valid", 0, rd_valid);
        end
        finish_test("clean round trip", err_start);

        run_injection("single data-bit error", 0, `ECC_DATA_WIDTH, 1, 1'b0);
        run_injection("check-bit error", `ECC_DATA_WIDTH, `ECC_PARITY_WIDTH, 1, 1'b0);
        run_injection("double error", 0, TOTAL_BITS, 2, 1'b0);
        run_injection("bypass", 0, TOTAL_BITS, 2, 1'b1);

        // Mix of clean, single and double error words.
        err_start = n_errors;
        n_single  = 0;
        for (int i = 0; i < `ECC_DEPTH; i++) begin
            kind          = rand_below(4);
            dflip         = '0;
            pflip         = '0;
            is_single[i]  = (kind == 1) || (kind == 2);
            clean_data[i] = rand_data();
            if (kind != 0) begin
                pick_flips(0, TOTAL_BITS, (kind == 3) ? 2 : 1, dflip, pflip);
            end
            if (is_single[i]) begin
                n_single++;
            end
            write_word(ecc_addr_t'(i), clean_data[i], dflip, pflip);
        end
        scrub_en = 1'b1;
        repeat (SCRUB_CYCLES) @(negedge clk);
        scrub_en = 1'b0;
        repeat (4) @(negedge clk); // Let a pending write-back land.
        if (corr_count !== ecc_count_t'(n_single)) begin
            report_err("corr_count", ecc_data_t'(n_single), ecc_data_t'(corr_count));
        end
        for (int i = 0; i < `ECC_DEPTH; i++) begin
            if (is_single[i]) begin
                shadow_data[i]   = clean_data[i];
                shadow_parity[i] = model_encode(clean_data[i]);
            end
            read_check(ecc_addr_t'(i), 1'b1);
            read_check(ecc_addr_t'(i), 1'b0); // Flags show the stored check bits.
        end
        finish_test("scrub repair", err_start);

        $display("%0d tests run, %0d errors", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        #((RUN_CYCLES + 200) * CLK_PERIOD);
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule
